// File: hw/sdi_pkg.sv
package sdi_pkg;

	// Command opcodes, upper nibble of the command byte
	localparam logic [3:0] sdi_op_ping = 4'h1;
	localparam logic [3:0] sdi_op_write = 4'h2;
	localparam logic [3:0] sdi_op_read = 4'h3;

	// Value answered to a ping
	localparam logic [31:0] sdi_ping_id = 32'h5d1c_0a17;

	// Leading byte of every UART response
	localparam logic [7:0] sdi_stat_ok = 8'ha5;
	localparam logic [7:0] sdi_stat_err = 8'he1;

	// Clocks per UART bit
	// kept small for short simulation runs
	localparam logic [15:0] sdi_baud_div = 16'd8;

	// Command byte plus four data bytes
	// response is status plus four data bytes
	localparam int sdi_frame_bytes = 5;

	// Debug register file
	localparam int sdi_reg_count = 8;
	// Index taken from the low command bits
	localparam int sdi_reg_idx_bits = $clog2(sdi_reg_count);

endpackage

// File: hw/sdi_uart.sv
`timescale 1ns/10ps
`default_nettype none

module sdi_uart import sdi_pkg::*; (
	input wire clock,
	input wire arst_n,
	// Serial lines
	input wire rxd,
	output logic txd,
	// Transmit side
	input wire tx_start,
	input wire [7:0] tx_byte,
	output logic tx_busy,
	// Receive side
	output logic rx_valid,
	output logic [7:0] rx_byte
);

	// Receiver state
	logic [1:0] rxd_sync;
	logic rx_active;
	logic [15:0] rx_cnt;
	logic [3:0] rx_bit;
	// Transmitter state
	logic [9:0] tx_shift;
	logic [15:0] tx_cnt;
	logic [3:0] tx_bit;

	// Two-flop synchronizer, then bit timing
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rxd_sync <= 2'b11;
			rx_active <= 1'b0;
			rx_cnt <= 16'd0;
			rx_bit <= 4'd0;
			rx_valid <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rx_valid <= 1'b0;
			if (!rx_active) begin
				// Start edge, wait half a bit to reach its middle
				if (!rxd_sync[1]) begin
					rx_active <= 1'b1;
					rx_cnt <= (sdi_baud_div >> 1) - 16'd1;
					rx_bit <= 4'd0;
				end
			end else if (rx_cnt != 16'd0) begin
				rx_cnt <= rx_cnt - 16'd1;
			end else begin
				rx_cnt <= sdi_baud_div - 16'd1;
				rx_bit <= rx_bit + 4'd1;
				if (rx_bit == 4'd0 && rxd_sync[1]) begin
					// Glitch, not a real start bit
					rx_active <= 1'b0;
				end else if (rx_bit == 4'd9) begin
					// Middle of stop bit
					rx_active <= 1'b0;
					rx_valid <= rxd_sync[1];
				end
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock) begin
		if (rx_active && rx_cnt == 16'd0 && rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
			rx_byte <= {rxd_sync[1], rx_byte[7:1]};
		end
	end

	// Stop, data and start bits in one shift word
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			tx_shift <= '1;
			tx_cnt <= 16'd0;
			tx_bit <= 4'd0;
			tx_busy <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_shift <= {1'b1, tx_byte, 1'b0};
				tx_cnt <= sdi_baud_div - 16'd1;
				tx_bit <= 4'd0;
				tx_busy <= 1'b1;
			end
		end else if (tx_cnt != 16'd0) begin
			tx_cnt <= tx_cnt - 16'd1;
		end else begin
			// Idle ones fill from the top
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_cnt <= sdi_baud_div - 16'd1;
			tx_bit <= tx_bit + 4'd1;
			if (tx_bit == 4'd9) begin
				tx_busy <= 1'b0;
			end
		end
	end

	assign txd = tx_shift[0];

endmodule

`default_nettype wire

// File: hw/sdi_uart_frame.sv
`timescale 1ns/10ps
`default_nettype none

module sdi_uart_frame import sdi_pkg::*; (
	input wire clock,
	input wire arst_n,
	// Byte UART
	input wire rx_valid,
	input wire [7:0] rx_byte,
	input wire tx_busy,
	output logic tx_start,
	output logic [7:0] tx_byte,
	// Toward the arbiter
	output logic req,
	output logic [7:0] cmd,
	output logic [31:0] data,
	input wire busy,
	input wire valid,
	input wire error,
	input wire [31:0] rdata,
	output logic host_busy
);

	logic [2:0] rx_count;
	logic [2:0] send_left;
	logic [39:0] resp_shift;
	logic tx_busy_q;

	// Frame byte counter
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rx_count <= 3'd0;
			req <= 1'b0;
		end else begin
			req <= 1'b0;
			if (rx_valid && busy) begin
				// Engine still working, drop the byte and resync
				rx_count <= 3'd0;
			end else if (rx_valid) begin
				if (rx_count == 3'(sdi_frame_bytes - 1)) begin
					rx_count <= 3'd0;
					req <= 1'b1;
				end else begin
					rx_count <= rx_count + 3'd1;
				end
			end
		end
	end

	// Command first, then data MSB first
	always_ff @(posedge clock) begin
		if (rx_valid && !busy) begin
			if (rx_count == 3'd0) begin
				cmd <= rx_byte;
			end else begin
				data <= {data[23:0], rx_byte};
			end
		end
	end

	// Response byte sequencing
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			send_left <= 3'd0;
			tx_start <= 1'b0;
			tx_busy_q <= 1'b0;
		end else begin
			tx_busy_q <= tx_busy;
			if (valid) begin
				send_left <= 3'(sdi_frame_bytes);
				tx_start <= 1'b1;
			end else if (tx_start) begin
				tx_start <= 1'b0;
				send_left <= send_left - 3'd1;
			end else if (tx_busy_q && !tx_busy && send_left != 3'd0) begin
				// Previous byte done
				tx_start <= 1'b1;
			end
		end
	end

	// Status byte leads the data
	always_ff @(posedge clock) begin
		if (valid) begin
			resp_shift <= {(error ? sdi_stat_err : sdi_stat_ok), rdata};
		end else if (tx_start) begin
			resp_shift <= {resp_shift[31:0], 8'h00};
		end
	end

	assign tx_byte = resp_shift[39:32];
	// Hold the engine off until the last byte has left
	assign host_busy = (send_left != 3'd0) || tx_busy;

endmodule

`default_nettype wire

// File: hw/sdi_interface_control.sv
`timescale 1ns/10ps
`default_nettype none

module sdi_interface_control (
	// 0 is UART, 1 is parallel
	input wire if_select,
	// Parallel port
	input wire para_req,
	input wire [7:0] para_cmd,
	input wire [31:0] para_data,
	input wire para_host_busy,
	output logic para_busy,
	output logic para_valid,
	output logic para_error,
	output logic [31:0] para_rdata,
	// UART framer
	input wire uart_req,
	input wire [7:0] uart_cmd,
	input wire [31:0] uart_data,
	input wire uart_host_busy,
	output logic uart_busy,
	output logic uart_valid,
	output logic uart_error,
	output logic [31:0] uart_rdata,
	// Common command port
	output logic com_req,
	output logic [7:0] com_cmd,
	output logic [31:0] com_data,
	output logic com_host_busy,
	input wire com_busy,
	input wire com_valid,
	input wire com_error,
	input wire [31:0] com_rdata
);

	// Request side, unselected request is lost
	always_comb begin
		if (if_select) begin
			com_req = para_req;
			com_cmd = para_cmd;
			com_data = para_data;
			com_host_busy = para_host_busy;
		end else begin
			com_req = uart_req;
			com_cmd = uart_cmd;
			com_data = uart_data;
			com_host_busy = uart_host_busy;
		end
	end

	// Response only to the selected path
	always_comb begin
		para_busy = if_select & com_busy;
		para_valid = if_select & com_valid;
		para_error = if_select & com_error;
		para_rdata = if_select ? com_rdata : 32'h0;
		uart_busy = !if_select & com_busy;
		uart_valid = !if_select & com_valid;
		uart_error = !if_select & com_error;
		uart_rdata = if_select ? 32'h0 : com_rdata;
	end

endmodule

`default_nettype wire

// File: hw/sdi_debug_core.sv
`timescale 1ns/10ps
`default_nettype none

module sdi_debug_core import sdi_pkg::*; (
	input wire clock,
	input wire arst_n,
	// Command in
	input wire req,
	input wire [7:0] cmd,
	input wire [31:0] data,
	input wire host_busy,
	// Response out
	output logic busy,
	output logic valid,
	output logic error,
	output logic [31:0] rdata
);

	logic [31:0] regs [sdi_reg_count];
	// Stage 1, accepted command
	logic s1_valid;
	logic [7:0] s1_cmd;
	logic [31:0] s1_data;
	// Stage 2, response register
	logic resp_pend;
	logic resp_error;
	// Execute results
	logic ex_error;
	logic [31:0] ex_data;
	logic [sdi_reg_idx_bits-1:0] s1_idx;

	assign s1_idx = s1_cmd[sdi_reg_idx_bits-1:0];

	// Opcode decode
	always_comb begin
		ex_error = 1'b0;
		ex_data = 32'h0;
		case (s1_cmd[7:4])
			sdi_op_ping: ex_data = sdi_ping_id;
			sdi_op_write: ex_data = s1_data;
			sdi_op_read: ex_data = regs[s1_idx];
			default: ex_error = 1'b1;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
			resp_pend <= 1'b0;
			regs <= '{default: 32'h0};
		end else begin
			s1_valid <= req & !busy;
			if (s1_valid) begin
				resp_pend <= 1'b1;
				if (s1_cmd[7:4] == sdi_op_write) begin
					regs[s1_idx] <= s1_data;
				end
			end else if (valid) begin
				resp_pend <= 1'b0;
			end
		end
	end

	// Command and answer payload
	always_ff @(posedge clock) begin
		if (req && !busy) begin
			s1_cmd <= cmd;
			s1_data <= data;
		end
		if (s1_valid) begin
			resp_error <= ex_error;
			rdata <= ex_data;
		end
	end

	// Answer waits while the host stalls
	assign valid = resp_pend & !host_busy;
	assign error = valid & resp_error;
	assign busy = s1_valid | resp_pend;

endmodule

`default_nettype wire

// File: hw/sdi_top.sv
`timescale 1ns/10ps
`default_nettype none

module sdi_top (
	input wire clock,
	input wire arst_n,
	input wire if_select,
	// UART lines
	input wire rxd,
	output logic txd,
	// Parallel port
	input wire para_req,
	input wire [7:0] para_cmd,
	input wire [31:0] para_data,
	input wire para_host_busy,
	output logic para_busy,
	output logic para_valid,
	output logic para_error,
	output logic [31:0] para_rdata
);

	// UART to framer
	logic rx_valid;
	logic [7:0] rx_byte;
	logic tx_start;
	logic [7:0] tx_byte;
	logic tx_busy;
	// Framer to arbiter
	logic uart_req;
	logic [7:0] uart_cmd;
	logic [31:0] uart_data;
	logic uart_host_busy;
	logic uart_busy;
	logic uart_valid;
	logic uart_error;
	logic [31:0] uart_rdata;
	// Arbiter to engine
	logic com_req;
	logic [7:0] com_cmd;
	logic [31:0] com_data;
	logic com_host_busy;
	logic com_busy;
	logic com_valid;
	logic com_error;
	logic [31:0] com_rdata;

	sdi_uart uart0 (
		.clock(clock), .arst_n(arst_n), .rxd(rxd), .txd(txd),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy),
		.rx_valid(rx_valid), .rx_byte(rx_byte)
	);

	sdi_uart_frame frame0 (
		.clock(clock), .arst_n(arst_n), .rx_valid(rx_valid), .rx_byte(rx_byte),
		.tx_busy(tx_busy), .tx_start(tx_start), .tx_byte(tx_byte),
		.req(uart_req), .cmd(uart_cmd), .data(uart_data), .busy(uart_busy),
		.valid(uart_valid), .error(uart_error), .rdata(uart_rdata),
		.host_busy(uart_host_busy)
	);

	sdi_interface_control ctrl0 (
		.if_select(if_select),
		.para_req(para_req), .para_cmd(para_cmd), .para_data(para_data),
		.para_host_busy(para_host_busy), .para_busy(para_busy),
		.para_valid(para_valid), .para_error(para_error), .para_rdata(para_rdata),
		.uart_req(uart_req), .uart_cmd(uart_cmd), .uart_data(uart_data),
		.uart_host_busy(uart_host_busy), .uart_busy(uart_busy),
		.uart_valid(uart_valid), .uart_error(uart_error), .uart_rdata(uart_rdata),
		.com_req(com_req), .com_cmd(com_cmd), .com_data(com_data),
		.com_host_busy(com_host_busy), .com_busy(com_busy),
		.com_valid(com_valid), .com_error(com_error), .com_rdata(com_rdata)
	);

	sdi_debug_core core0 (
		.clock(clock), .arst_n(arst_n),
		.req(com_req), .cmd(com_cmd), .data(com_data), .host_busy(com_host_busy),
		.busy(com_busy), .valid(com_valid), .error(com_error), .rdata(com_rdata)
	);

endmodule

`default_nettype wire

// File: sim/tb_sdi.sv
`timescale 1ns/10ps

module tb_sdi import sdi_pkg::*; ();

	// Trace layout of five words per transaction
	localparam int trace_fields = 5;
	localparam int trace_max = 64;
	localparam logic [31:0] path_end = 32'hf;
	localparam int baud = int'(sdi_baud_div);
	localparam int para_wait_limit = 32;
	localparam int uart_wait_limit = 40 * baud;

	logic clock;
	logic arst_n;
	logic if_select;
	logic rxd;
	logic para_req;
	logic [7:0] para_cmd;
	logic [31:0] para_data;
	logic para_host_busy;
	wire txd;
	wire para_busy;
	wire para_valid;
	wire para_error;
	wire [31:0] para_rdata;

	logic [31:0] trace_mem [trace_fields*trace_max];
	logic [31:0] lfsr_state;

	sdi_top dut0 (
		.clock(clock), .arst_n(arst_n), .if_select(if_select),
		.rxd(rxd), .txd(txd),
		.para_req(para_req), .para_cmd(para_cmd), .para_data(para_data),
		.para_host_busy(para_host_busy), .para_busy(para_busy),
		.para_valid(para_valid), .para_error(para_error), .para_rdata(para_rdata)
	);

	// 40 ns period
	always #20 clock = ~clock;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		// Galois form with taps 32 22 2 1
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// Stall of 0 to 7 cycles with one LFSR step per bit
	task automatic draw_stall(output int stall);
		logic [2:0] bits;
		bits = 3'd0;
		for (int i = 0; i < 3; i++) begin
			bits = {bits[1:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		stall = int'(bits);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	// Parallel request optionally stalled by host busy
	task automatic para_transfer(input string tname, input logic [7:0] cmd,
			input logic [31:0] data, input int stall, input bit want_resp,
			input logic exp_error, input logic [31:0] exp_rdata);
		int n;
		bit seen;
		n = 0;
		@(negedge clock);
		while (para_busy !== 1'b0) begin
			if (n == para_wait_limit) begin
				abort_run($sformatf("%s: parallel port stayed busy", tname));
			end
			n++;
			@(negedge clock);
		end
		@(posedge clock);
		para_req <= 1'b1;
		para_cmd <= cmd;
		para_data <= data;
		para_host_busy <= 1'b1;
		n = 0;
		seen = 1'b0;
		while (!seen && n < para_wait_limit) begin
			@(negedge clock);
			if (para_valid === 1'b1) begin
				seen = 1'b1;
			end else begin
				// Busy from the cycle after the request
				if (n >= 1 || !want_resp) begin
					check_value($sformatf("%s para_busy", tname),
						{31'd0, want_resp}, {31'd0, para_busy});
				end
				@(posedge clock);
				para_req <= 1'b0;
				n++;
				// Release in the cycle the answer is due
				para_host_busy <= (n < 2 + stall);
			end
		end
		if (want_resp) begin
			if (!seen) begin
				abort_run($sformatf("%s: no parallel response before the timeout", tname));
			end
			check_value($sformatf("%s latency", tname), 2 + stall, n);
			check_value($sformatf("%s error", tname), {31'd0, exp_error}, {31'd0, para_error});
			check_value($sformatf("%s rdata", tname), exp_rdata, para_rdata);
		end else begin
			check_value($sformatf("%s dropped request", tname), 32'd0, {31'd0, seen});
		end
		@(posedge clock);
		para_req <= 1'b0;
		para_host_busy <= 1'b0;
	endtask

	// 8N1 frame sent LSB first
	task automatic uart_send_byte(input logic [7:0] value);
		logic [9:0] bits;
		bits = {1'b1, value, 1'b0};
		for (int b = 0; b < 10; b++) begin
			@(posedge clock);
			rxd <= bits[b];
			repeat (baud - 1) @(posedge clock);
		end
	endtask

	task automatic uart_recv_byte(input string tname, output logic [7:0] value);
		int n;
		n = 0;
		@(negedge clock);
		while (txd !== 1'b0) begin
			if (n == uart_wait_limit) begin
				abort_run($sformatf("%s: no start bit on txd before the timeout", tname));
			end
			n++;
			@(negedge clock);
		end
		// Middle of the start bit
		repeat (baud / 2) @(negedge clock);
		check_value($sformatf("%s start bit", tname), 32'd0, {31'd0, txd});
		for (int b = 0; b < 8; b++) begin
			repeat (baud) @(negedge clock);
			value[b] = txd;
		end
		repeat (baud) @(negedge clock);
		check_value($sformatf("%s stop bit", tname), 32'd1, {31'd0, txd});
	endtask

	task automatic uart_transfer(input string tname, input logic [7:0] cmd,
			input logic [31:0] data, input bit want_resp,
			input logic exp_error, input logic [31:0] exp_rdata);
		logic [39:0] expect_bytes;
		logic [7:0] got;
		uart_send_byte(cmd);
		for (int i = 3; i >= 0; i--) begin
			uart_send_byte(data[8*i +: 8]);
		end
		if (want_resp) begin
			// Status byte then data MSB first
			expect_bytes = {(exp_error ? sdi_stat_err : sdi_stat_ok), exp_rdata};
			for (int i = 0; i < sdi_frame_bytes; i++) begin
				uart_recv_byte(tname, got);
				check_value($sformatf("%s byte %0d", tname, i),
					{24'd0, expect_bytes[39:32]}, {24'd0, got});
				expect_bytes = expect_bytes << 8;
			end
		end else begin
			// Line stays idle while the engine belongs to the parallel port
			for (int k = 0; k < uart_wait_limit; k++) begin
				@(negedge clock);
				check_value($sformatf("%s idle txd", tname), 32'd1, {31'd0, txd});
			end
		end
	endtask

	initial begin
		int idx;
		int base;
		int stall;
		logic [31:0] path;
		string tname;
		clock = 1'b0;
		arst_n = 1'b0;
		if_select = 1'b1;
		rxd = 1'b1;
		para_req = 1'b0;
		para_cmd = 8'h00;
		para_data = 32'h0;
		para_host_busy = 1'b0;
		lfsr_state = 32'h11f5;
		// Sentinel survives only if the trace file is missing
		trace_mem[0] = 32'hffff_ffff;
		$readmemh("sim/sdi_trace.txt", trace_mem);
		if (trace_mem[0] === 32'hffff_ffff) begin
			abort_run("trace file sim/sdi_trace.txt could not be read");
		end
		repeat (3) @(posedge clock);
		arst_n <= 1'b1;
		// Idle levels after reset
		@(negedge clock);
		check_value("reset txd", 32'd1, {31'd0, txd});
		check_value("reset para_busy", 32'd0, {31'd0, para_busy});
		check_value("reset para_valid", 32'd0, {31'd0, para_valid});
		check_value("reset para_error", 32'd0, {31'd0, para_error});
		idx = 0;
		while (idx < trace_max && trace_mem[idx*trace_fields] !== path_end) begin
			base = idx * trace_fields;
			path = trace_mem[base];
			tname = $sformatf("trace %0d", idx);
			@(posedge clock);
			if_select <= (path == 32'd0 || path == 32'd1 || path == 32'd4);
			case (path)
				32'd0: para_transfer(tname, trace_mem[base+1][7:0], trace_mem[base+2], 0,
					1'b1, trace_mem[base+3][0], trace_mem[base+4]);
				32'd1: begin
					draw_stall(stall);
					para_transfer(tname, trace_mem[base+1][7:0], trace_mem[base+2], stall,
						1'b1, trace_mem[base+3][0], trace_mem[base+4]);
				end
				32'd2: uart_transfer(tname, trace_mem[base+1][7:0], trace_mem[base+2],
					1'b1, trace_mem[base+3][0], trace_mem[base+4]);
				32'd3: para_transfer(tname, trace_mem[base+1][7:0], trace_mem[base+2], 0,
					1'b0, trace_mem[base+3][0], trace_mem[base+4]);
				32'd4: uart_transfer(tname, trace_mem[base+1][7:0], trace_mem[base+2],
					1'b0, trace_mem[base+3][0], trace_mem[base+4]);
				default: abort_run($sformatf("%s: unknown path code %h", tname, path));
			endcase
			idx++;
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// File: sim/sdi_trace.txt
// path: 0 parallel, 1 parallel stalled, 2 UART, 3 parallel dropped, 4 UART dropped, f end
// columns: path cmd data expected_error expected_rdata
0 23 12345678 0 12345678
0 33 00000000 0 12345678
0 10 00000000 0 5d1c0a17
0 25 a5a5f00d 0 a5a5f00d
0 75 ffffffff 1 00000000
0 35 00000000 0 a5a5f00d
1 21 0badcafe 0 0badcafe
1 31 00000000 0 0badcafe
1 10 00000000 0 5d1c0a17
1 f2 00000000 1 00000000
2 10 00000000 0 5d1c0a17
2 26 89abcdef 0 89abcdef
2 36 00000000 0 89abcdef
2 00 00000000 1 00000000
0 36 00000000 0 89abcdef
2 33 00000000 0 12345678
3 27 deadbeef 0 00000000
0 37 00000000 0 00000000
4 27 feedface 0 00000000
0 37 00000000 0 00000000
2 37 00000000 0 00000000
f 00 00000000 0 00000000

// File: tb.f
hw/sdi_pkg.sv
hw/sdi_uart.sv
hw/sdi_uart_frame.sv
hw/sdi_interface_control.sv
hw/sdi_debug_core.sv
hw/sdi_top.sv
sim/tb_sdi.sv

// File: run.sh
#!/bin/sh
# Build and run the SDI testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --top-module tb_sdi -f tb.f -Mdir "$build_dir" -o tb_sdi_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/tb_sdi_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1
